// ==== rtl/router_pkg.sv ====
//##########################################################################
// router_pkg: port count, port number and port vector types, and the
// header field lengths of an input frame
//##########################################################################

package router_pkg;

  // sixteen serial input ports and sixteen output ports
  localparam int num_ports = 16;

  // a port number
  typedef logic [3:0] port_idx_t;

  // one bit per port, bit i belongs to port i
  typedef logic [num_ports-1:0] port_vec_t;

  // destination address bits at frame start, lsb first
  localparam int addr_bits = 4;

  // minimum padding cycles between the address and the payload
  localparam int pad_bits = 4;

endpackage

// ==== rtl/host_pkg.sv ====
//##########################################################################
// host_pkg: host word and address types, address map of the identity,
// lock and counter registers, identity constants
//##########################################################################

package host_pkg;

  typedef logic [15:0] host_word_t;

  // same address word seen flat, or split into counter page and index
  typedef union packed {
    logic [15:0] flat;
    struct packed {
      logic [7:0] page;
      logic [7:0] offset;
    } fields;
  } host_addr_u;

  localparam logic [7:0] chip_id = 8'h5a;
  localparam logic [7:0] rev_id  = 8'h03;
  localparam host_word_t host_id = {chip_id, rev_id};

  localparam host_word_t id_addr   = 16'h0000;
  localparam host_word_t lock_addr = 16'h0100;

  // counters live at page 'h20, offsets 0 to 31
  localparam logic [7:0] cnt_page = 8'h20;

  // 16 input frame counters followed by 16 output frame counters
  localparam int num_counters = 32;

endpackage

// ==== rtl/input_port.sv ====
//##########################################################################
// input_port: frame header decoder and output port request FSM
//##########################################################################

`timescale 1ns/1ns

module input_port
  import router_pkg::*;
(
  input  logic      io,
  input  logic      arst_n,
  input  logic      lock,
  input  logic      frame_n,
  input  logic      din,
  input  port_vec_t grant_n,
  output port_vec_t request_n,
  output logic      busy_n
);

  // states 0..3 address, 4..5 pad, 6 request, 7 wait for grant, 8 data
  logic [3:0] state;
  logic [3:0] state_nxt;
  port_idx_t  dest;
  port_idx_t  dest_nxt;
  logic       busy_nxt;
  logic       pad_bad;

  // a padding cycle needs frame low and din high
  assign pad_bad = frame_n | ~din;

  always_ff @(posedge io or negedge arst_n) begin
    if (!arst_n) begin
      state  <= '0;
      dest   <= '0;
      busy_n <= 1'b1;
    end else if (!lock) begin
      state  <= state_nxt;
      dest   <= dest_nxt;
      busy_n <= busy_nxt;
    end
  end

  always_comb begin
    state_nxt = state + 4'd1;
    dest_nxt  = dest;
    busy_nxt  = 1'b1;
    request_n = '1;
    if (state < addr_bits) begin
      // address bit number equals the state
      if (frame_n) state_nxt = '0;
      else dest_nxt[state[1:0]] = din;
    end else if (state < addr_bits + pad_bits - 2) begin
      if (pad_bad) state_nxt = '0;
    end else if (state == addr_bits + pad_bits - 2) begin
      if (pad_bad) state_nxt = '0;
      else request_n[dest] = 1'b0;
    end else if (state == addr_bits + pad_bits - 1) begin
      if (pad_bad) begin
        state_nxt = '0;
      end else if (grant_n[dest]) begin
        // no grant yet, keep asking and tell the sender to pad
        request_n[dest] = 1'b0;
        busy_nxt        = 1'b0;
        state_nxt       = state;
      end
    end else if (state == addr_bits + pad_bits) begin
      if (frame_n) state_nxt = '0;
      else state_nxt = state;
    end else begin
      state_nxt = '0;
    end
  end

endmodule

// ==== rtl/output_port.sv ====
//##########################################################################
// output_port: round-robin arbiter over the input ports, grant FSM and
// selection of the granted source onto the serial output
//##########################################################################

`timescale 1ns/1ns

module output_port
  import router_pkg::*;
(
  input  logic      io,
  input  logic      arst_n,
  input  logic      lock,
  input  port_vec_t request_n,
  input  port_vec_t din_q,
  input  port_vec_t frame_q,
  input  port_vec_t valid_q,
  output port_vec_t grant_n,
  output logic      dout,
  output logic      frameo_n,
  output logic      valido_n
);

  // one-hot: bit 0 idle, bit 1 grant, bit 2 transfer
  logic [2:0] state;
  logic [2:0] state_nxt;

  // current source, also the start point of the next search
  port_idx_t src;
  port_idx_t src_nxt;

  port_idx_t                  first;
  port_idx_t                  offset;
  port_idx_t                  pick;
  logic                       hit;
  port_vec_t                  req;
  port_vec_t                  req_rot;
  logic [2*num_ports-1:0]     req_dbl;

  assign req   = ~request_n;
  assign first = src + 4'd1;

  // rotate so that bit 0 is the port right after the last one granted
  assign req_dbl = {req, req} >> first;
  assign req_rot = req_dbl[num_ports-1:0];

  always_comb begin
    hit    = 1'b0;
    offset = '0;
    for (int i = num_ports - 1; i >= 0; i--) begin
      if (req_rot[i]) begin
        hit    = 1'b1;
        offset = port_idx_t'(i);
      end
    end
  end

  assign pick = first + offset;

  always_ff @(posedge io or negedge arst_n) begin
    if (!arst_n) begin
      state <= 3'b001;
      src   <= '1;
    end else if (!lock) begin
      state <= state_nxt;
      src   <= src_nxt;
    end
  end

  always_comb begin
    state_nxt = '0;
    src_nxt   = src;
    grant_n   = '1;
    case (1'b1)
      state[0]: begin
        if (hit) begin
          src_nxt      = pick;
          state_nxt[1] = 1'b1;
        end else begin
          state_nxt[0] = 1'b1;
        end
      end
      state[1]: begin
        grant_n[src] = 1'b0;
        state_nxt[2] = 1'b1;
      end
      state[2]: begin
        // source frame ended when its sampled frame_n rises
        if (frame_q[src]) state_nxt[0] = 1'b1;
        else state_nxt[2] = 1'b1;
      end
      default: state_nxt[0] = 1'b1;
    endcase
  end

  // the source bits arrive here one cycle late through the sampling registers
  assign dout     = din_q[src];
  assign frameo_n = state[0] | frame_q[src];
  assign valido_n = state[0] | valid_q[src];

endmodule

// ==== rtl/host_regs.sv ====
//##########################################################################
// host_regs: identity word, port lock register, input and output frame
// counters and the host read decode
//##########################################################################

`timescale 1ns/1ns

module host_regs
  import router_pkg::*;
  import host_pkg::*;
(
  input  logic       io,
  input  logic       arst_n,
  input  port_vec_t  frame_n,
  input  port_vec_t  frameo_n,
  input  host_addr_u host_address,
  input  logic       host_wr_n,
  input  host_word_t host_wdata,
  output host_word_t host_rdata,
  output port_vec_t  lock
);

  port_vec_t  frame_prev;
  port_vec_t  frameo_prev;
  port_vec_t  frame_rise;
  port_vec_t  frameo_rise;
  host_word_t cnt [num_counters];

  // a frame is complete when its frame line goes back high
  assign frame_rise  = ~frame_prev & frame_n;
  assign frameo_rise = ~frameo_prev & frameo_n;

  always_ff @(posedge io or negedge arst_n) begin
    if (!arst_n) begin
      frame_prev  <= '1;
      frameo_prev <= '1;
    end else begin
      frame_prev  <= frame_n;
      frameo_prev <= frameo_n;
    end
  end

  // counters 0..15 count input frames, 16..31 output frames
  always_ff @(posedge io or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_counters; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < num_ports; i++) begin
        if (frame_rise[i]) cnt[i] <= cnt[i] + 16'd1;
        if (frameo_rise[i]) cnt[num_ports + i] <= cnt[num_ports + i] + 16'd1;
      end
    end
  end

  // all ports start locked, a one in the written word unlocks that port
  always_ff @(posedge io or negedge arst_n) begin
    if (!arst_n) begin
      lock <= '1;
    end else if (!host_wr_n && host_address.flat == lock_addr) begin
      lock <= lock & ~host_wdata;
    end
  end

  always_comb begin
    host_rdata = '0;
    if (host_wr_n) begin
      if (host_address.flat == id_addr) begin
        host_rdata = host_id;
      end else if (host_address.flat == lock_addr) begin
        host_rdata = lock;
      end else if (host_address.fields.page == cnt_page &&
                   host_address.fields.offset < num_counters) begin
        host_rdata = cnt[host_address.fields.offset[4:0]];
      end
    end
  end

endmodule

// ==== rtl/router_top.sv ====
//##########################################################################
// router_top: input sampling registers, request and grant matrix
// transposition, the 16 input and output ports and the host registers
//##########################################################################

`timescale 1ns/1ns

module router_top
  import router_pkg::*;
  import host_pkg::*;
(
  input  logic            io,
  input  logic            arst_n,
  input  port_vec_t       frame_n,
  input  port_vec_t       valid_n,
  input  port_vec_t       din,
  output wire port_vec_t  dout,
  output wire port_vec_t  frameo_n,
  output wire port_vec_t  valido_n,
  output wire port_vec_t  busy_n,
  input  host_addr_u      host_address,
  input  logic            host_wr_n,
  input  host_word_t      host_wdata,
  output host_word_t      host_rdata
);

  port_vec_t din_q;
  port_vec_t frame_q;
  port_vec_t valid_q;
  port_vec_t lock;

  // input i asks for output o in request_in[i][o] and request_out is the transpose
  port_vec_t request_in  [num_ports];
  port_vec_t request_out [num_ports];
  // output o grants input i in grant_out[o][i] and grant_in is the transpose
  port_vec_t grant_out   [num_ports];
  port_vec_t grant_in    [num_ports];

  // one cycle copy of every input line for all output ports
  always_ff @(posedge io or negedge arst_n) begin
    if (!arst_n) begin
      din_q   <= '1;
      frame_q <= '1;
      valid_q <= '1;
    end else begin
      din_q   <= din;
      frame_q <= frame_n;
      valid_q <= valid_n;
    end
  end

  always_comb begin
    for (int o = 0; o < num_ports; o++) begin
      for (int i = 0; i < num_ports; i++) begin
        request_out[o][i] = request_in[i][o];
        grant_in[i][o]    = grant_out[o][i];
      end
    end
  end

  for (genvar p = 0; p < num_ports; p++) begin : g_port
    input_port u_input_port (
      .io        (io),
      .arst_n    (arst_n),
      .lock      (lock[p]),
      .frame_n   (frame_n[p]),
      .din       (din[p]),
      .grant_n   (grant_in[p]),
      .request_n (request_in[p]),
      .busy_n    (busy_n[p])
    );

    output_port u_output_port (
      .io        (io),
      .arst_n    (arst_n),
      .lock      (lock[p]),
      .request_n (request_out[p]),
      .din_q     (din_q),
      .frame_q   (frame_q),
      .valid_q   (valid_q),
      .grant_n   (grant_out[p]),
      .dout      (dout[p]),
      .frameo_n  (frameo_n[p]),
      .valido_n  (valido_n[p])
    );
  end

  host_regs u_host_regs (
    .io           (io),
    .arst_n       (arst_n),
    .frame_n      (frame_n),
    .frameo_n     (frameo_n),
    .host_address (host_address),
    .host_wr_n    (host_wr_n),
    .host_wdata   (host_wdata),
    .host_rdata   (host_rdata),
    .lock         (lock)
  );

endmodule

// ==== dv/router_props.sv ====
//##########################################################################
// router_props: concurrent assertions bound to the router top level
//##########################################################################

`timescale 1ns/1ns

module router_props
  import router_pkg::*;
  import host_pkg::*;
(
  input logic       io,
  input logic       arst_n,
  input port_vec_t  frameo_n,
  input port_vec_t  valido_n,
  input port_vec_t  busy_n,
  input port_vec_t  lock,
  input host_addr_u host_address,
  input logic       host_wr_n,
  input host_word_t host_rdata
);

  // a valid output bit only inside an output frame
  valid_in_frame: assert property (@(posedge io) disable iff (!arst_n)
    (~valido_n & frameo_n) == '0)
    else $error("valido_n low outside an output frame");

  // a locked input port never holds its sender off
  locked_not_busy: assert property (@(posedge io) disable iff (!arst_n)
    (busy_n & lock) == lock)
    else $error("busy_n low on a locked port");

  id_read: assert property (@(posedge io) disable iff (!arst_n)
    (host_wr_n && host_address.flat == id_addr) |-> host_rdata == host_id)
    else $error("identity read returned a wrong word");

endmodule

bind router_top router_props u_router_props (
  .io           (io),
  .arst_n       (arst_n),
  .frameo_n     (frameo_n),
  .valido_n     (valido_n),
  .busy_n       (busy_n),
  .lock         (lock),
  .host_address (host_address),
  .host_wr_n    (host_wr_n),
  .host_rdata   (host_rdata)
);

// ==== dv/router_tb.sv ====
//##########################################################################
// router_tb: clock, reset, LFSR stimulus, packet senders, host accesses,
// reference model with per-source queues, output monitor and watchdog
//##########################################################################

`timescale 1ns/1ns

module router_tb
  import router_pkg::*;
  import host_pkg::*;
;

  localparam int max_len  = 32;
  localparam int max_pkt  = addr_bits + pad_bits + max_len + 3;
  localparam int n_single = 40;
  localparam int n_rounds = 12;
  localparam int per_src  = 2;
  localparam int n_pkts   = 1 + n_single + n_rounds * num_ports * per_src;
  localparam longint timeout_ns = longint'(n_pkts) * (max_pkt + 16 * max_pkt) * 20 + 20000;

  logic       io;
  logic       arst_n;
  port_vec_t  frame_n;
  port_vec_t  valid_n;
  port_vec_t  din;
  port_vec_t  dout;
  port_vec_t  frameo_n;
  port_vec_t  valido_n;
  port_vec_t  busy_n;
  host_addr_u host_address;
  logic       host_wr_n;
  host_word_t host_wdata;
  host_word_t host_rdata;

  // model entries hold {length, payload} with payload bit 0 sent first
  logic [39:0] exp_q [num_ports][num_ports][$];
  int          in_cnt [num_ports];
  int          out_cnt [num_ports];
  int          pending;
  host_word_t  lock_model;
  logic [31:0] lfsr;
  logic [31:0] rx_data [num_ports];
  int          rx_len [num_ports];
  logic        rx_active [num_ports];

  router_top DUT (.*);

  always #10 io = ~io;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
      $display("Simulation failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic host_read(input host_word_t addr, output host_word_t data);
    host_address.flat = addr;
    host_wr_n = 1'b1;
    #5;
    data = host_rdata;
    @(negedge io);
  endtask

  task automatic host_write(input host_word_t addr, input host_word_t data);
    host_address.flat = addr;
    host_wdata = data;
    host_wr_n = 1'b0;
    @(negedge io);
    host_wr_n = 1'b1;
  endtask

  // starts on a falling edge and sends the address lsb first, then pads until busy_n is high
  task automatic send_packet(input int p, input port_idx_t dest, input bit delivered,
                             input bit may_wait);
    logic [31:0] r;
    logic [31:0] data;
    int len;
    rand_bits(5, r);
    len = 4 + int'(r) % (max_len - 3);
    rand_bits(32, data);
    data[3:0] = port_idx_t'(p);
    if (len < 32) data = data & (32'hffffffff >> (32 - len));
    in_cnt[p]++;
    if (delivered) begin
      exp_q[dest][p].push_back({8'(len), data});
      out_cnt[dest]++;
      pending++;
    end
    for (int b = 0; b < addr_bits; b++) begin
      frame_n[p] = 1'b0;
      valid_n[p] = 1'b1;
      din[p] = dest[b];
      @(negedge io);
    end
    din[p] = 1'b1;
    repeat (pad_bits) @(negedge io);
    // an idle output port grants in time for the minimum padding
    if (!may_wait) check(busy_n[p], 1'b1, $sformatf("busy_n on uncontended input %0d", p));
    while (!busy_n[p]) @(negedge io);
    for (int k = 0; k < len; k++) begin
      valid_n[p] = 1'b0;
      din[p] = data[k];
      @(negedge io);
    end
    frame_n[p] = 1'b1;
    valid_n[p] = 1'b1;
    din[p] = 1'b1;
    repeat (2) @(negedge io);
  endtask

  task automatic send_burst(input int p, input port_idx_t dest);
    repeat (per_src) send_packet(p, dest, 1'b1, 1'b1);
  endtask

  // output frames are collected at the falling edge where they are stable
  always @(negedge io) begin
    logic [39:0] entry;
    port_idx_t src;
    for (int o = 0; o < num_ports; o++) begin
      if (!frameo_n[o]) begin
        rx_active[o] = 1'b1;
        if (!valido_n[o]) begin
          rx_data[o][rx_len[o]] = dout[o];
          rx_len[o]++;
        end
      end else if (rx_active[o]) begin
        src = rx_data[o][3:0];
        check(exp_q[o][src].size() != 0, 1, $sformatf("unexpected frame on output %0d", o));
        entry = exp_q[o][src].pop_front();
        check(rx_len[o], entry[39:32], $sformatf("length on output %0d from %0d", o, src));
        check(rx_data[o], entry[31:0], $sformatf("payload on output %0d from %0d", o, src));
        rx_active[o] = 1'b0;
        rx_len[o] = 0;
        rx_data[o] = '0;
        pending--;
      end
    end
  end

  initial begin
    #(timeout_ns);
    $display("run timed out before all packets were delivered");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] r;
    host_word_t  rd;
    io = 1'b0;
    arst_n = 1'b0;
    frame_n = '1;
    valid_n = '1;
    din = '1;
    host_address = '0;
    host_wr_n = 1'b1;
    host_wdata = '0;
    lfsr = 32'he42fe814;
    lock_model = '1;
    pending = 0;
    for (int i = 0; i < num_ports; i++) begin
      in_cnt[i] = 0;
      out_cnt[i] = 0;
      rx_data[i] = '0;
      rx_len[i] = 0;
      rx_active[i] = 1'b0;
    end
    repeat (10) @(posedge io);
    @(negedge io);
    arst_n = 1'b1;
    @(negedge io);

    host_read(id_addr, rd);
    check(rd, 16'h5a03, "identity word");
    host_read(lock_addr, rd);
    check(rd, 16'hffff, "lock word after reset");
    // a locked port counts the input frame but delivers nothing
    send_packet(3, 4'd3, 1'b0, 1'b0);
    repeat (10) @(negedge io);

    repeat (8) begin
      rand_bits(16, r);
      host_write(lock_addr, r[15:0]);
      lock_model = lock_model & ~r[15:0];
      host_read(lock_addr, rd);
      check(rd, lock_model, "lock word after write");
    end
    host_write(lock_addr, 16'hffff);
    host_read(lock_addr, rd);
    check(rd, 16'h0000, "lock word after unlock all");

    repeat (n_single) begin
      rand_bits(8, r);
      send_packet(int'(r[7:4]), r[3:0], 1'b1, 1'b0);
      while (pending > 0) @(negedge io);
    end

    // several senders to one output port at once
    repeat (n_rounds) begin
      rand_bits(20, r);
      for (int k = 0; k < num_ports; k++) begin
        automatic int s = k;
        automatic port_idx_t d = r[19:16];
        if (r[k]) begin
          fork
            send_burst(s, d);
          join_none
        end
      end
      wait fork;
      while (pending > 0) @(negedge io);
    end
    repeat (4) @(negedge io);

    for (int i = 0; i < num_ports; i++) begin
      host_read({cnt_page, 8'(i)}, rd);
      check(rd, in_cnt[i], $sformatf("input frame counter %0d", i));
      host_read({cnt_page, 8'(num_ports + i)}, rd);
      check(rd, out_cnt[i], $sformatf("output frame counter %0d", i));
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== all.f ====
rtl/router_pkg.sv
rtl/host_pkg.sv
rtl/input_port.sv
rtl/output_port.sv
rtl/host_regs.sv
rtl/router_top.sv
dv/router_props.sv
dv/router_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module router_tb -o sim

./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
grep -q "Simulation completed successfully" sim.log
